// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int NB_REG     = 5;
    localparam int NB_DATA    = 32;
    localparam int NB_MUX     = 2;
    localparam int DMEM_WORDS = 64;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LBU   = 6'h24;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
    } alu_op_t;

    // ALU operand source
    typedef enum logic [NB_MUX-1:0] {
        FWD_NONE = 2'b00,  // Register file value
        FWD_MEM  = 2'b01,  // EX/MEM result
        FWD_WB   = 2'b10   // MEM/WB value
    } fwd_sel_t;

    // Store data source, same encoding as the original store mux
    typedef enum logic [NB_MUX-1:0] {
        STORE_MEM    = 2'b00,
        STORE_WB     = 2'b01,
        STORE_NORMAL = 2'b10
    } store_sel_t;

    typedef struct packed {
        logic               valid;
        alu_op_t            alu_op;
        logic               use_imm;
        logic [NB_DATA-1:0] imm;
        logic [NB_DATA-1:0] data_a;
        logic [NB_DATA-1:0] data_b;
        logic [NB_REG-1:0]  rs;
        logic [NB_REG-1:0]  rt;
        logic [NB_REG-1:0]  rd;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic               byte_en;    // LBU or SB
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_DATA-1:0] store_data;
        logic [NB_REG-1:0]  rd;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        logic               byte_en;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [NB_DATA-1:0] wdata;
        logic [NB_REG-1:0]  rd;
        logic               reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic               valid;
        logic [NB_REG-1:0]  rd;
        logic [NB_DATA-1:0] wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: verilog/pipeline_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_reg #(
    parameter type T = logic [31:0]
) (
    input  wire logic i_clk,
    input  wire logic i_reset,
    input  wire logic i_flush,
    input  wire T     i_d,
    output T          o_q
);

    // An all-zero payload has valid and every write enable low
    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_q <= '0;
        end else begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic        i_stall,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic [31:0]      o_wb_adr,
    input  wire logic [31:0] i_wb_dat,
    input  wire logic        i_wb_ack,
    output logic [31:0]      o_instr,
    output logic             o_instr_valid
);

    logic [31:0] pc_q;
    logic        cyc_q;
    logic [31:0] instr_q;
    logic        instr_valid_q;
    logic [31:0] skid_q;
    logic        skid_valid_q;
    logic        bus_done;

    assign bus_done = cyc_q && i_wb_ack;  // Transfer ends on this edge

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q          <= '0;
            cyc_q         <= 1'b0;
            instr_valid_q <= 1'b0;
            skid_valid_q  <= 1'b0;
        end else begin
            if (bus_done) begin
                cyc_q <= !i_stall;           // Back-to-back unless decode is held
                pc_q  <= pc_q + 32'd4;
            end else if (!cyc_q && !i_stall) begin
                cyc_q <= 1'b1;               // Next fetch
            end
            if (!i_stall) begin
                instr_valid_q <= skid_valid_q || bus_done;
                skid_valid_q  <= 1'b0;
            end else if (bus_done) begin
                skid_valid_q  <= 1'b1;       // Park word until decode frees up
            end
        end
    end

    // Skid slot is drained before the next bus cycle can finish
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            instr_q <= skid_valid_q ? skid_q : i_wb_dat;
        end else if (bus_done) begin
            skid_q <= i_wb_dat;
        end
    end

    assign o_wb_cyc      = cyc_q;
    assign o_wb_stb      = cyc_q;
    assign o_wb_adr      = pc_q;
    assign o_instr       = instr_q;
    assign o_instr_valid = instr_valid_q;

    a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr));

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                         i_clk,
    input  wire logic                         i_reset,
    input  wire logic [mips_pkg::NB_REG-1:0]  i_rs,
    input  wire logic [mips_pkg::NB_REG-1:0]  i_rt,
    output logic [mips_pkg::NB_DATA-1:0]      o_data_a,
    output logic [mips_pkg::NB_DATA-1:0]      o_data_b,
    input  wire logic                         i_we,
    input  wire logic [mips_pkg::NB_REG-1:0]  i_waddr,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_wdata
);

    import mips_pkg::*;

    logic [NB_DATA-1:0] regs [2**NB_REG];
    logic               wr_ok;

    assign wr_ok = i_we && (i_waddr != '0);  // r0 stays zero

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2**NB_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Write-through covers the distance-3 dependency
    assign o_data_a = (wr_ok && i_waddr == i_rs) ? i_wdata : regs[i_rs];
    assign o_data_b = (wr_ok && i_waddr == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire logic [31:0]                  i_instr,
    input  wire logic                         i_instr_valid,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_rf_data_a,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_rf_data_b,
    output logic [mips_pkg::NB_REG-1:0]       o_rs,
    output logic [mips_pkg::NB_REG-1:0]       o_rt,
    input  wire logic [mips_pkg::NB_REG-1:0]  i_ex_rd,
    input  wire logic                         i_ex_mem_read,
    output logic                              o_stall,
    output mips_pkg::id_ex_t                  o_id_ex
);

    import mips_pkg::*;

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [NB_REG-1:0] dest;
    logic              is_rtype;
    logic              is_load;
    logic              is_store;
    logic              known;
    logic              uses_rs;
    logic              uses_rt;
    alu_op_t           alu_op;
    logic [NB_DATA-1:0] imm;

    assign opcode   = i_instr[31:26];
    assign funct    = i_instr[5:0];
    assign o_rs     = i_instr[25:21];
    assign o_rt     = i_instr[20:16];
    assign is_rtype = (opcode == OP_RTYPE);
    assign is_load  = (opcode == OP_LW) || (opcode == OP_LBU);
    assign is_store = (opcode == OP_SW) || (opcode == OP_SB);
    assign dest     = is_rtype ? i_instr[15:11] : o_rt;
    assign uses_rs  = (opcode != OP_LUI);
    assign uses_rt  = is_rtype || is_store;   // Store data comes from rt

    always_comb begin
        alu_op = ALU_ADD;
        imm    = {{16{i_instr[15]}}, i_instr[15:0]};
        known  = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: known  = 1'b0;   // NOP lands here
                endcase
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                imm    = {16'h0000, i_instr[15:0]};
            end
            OP_LUI:                           alu_op = ALU_LUI;
            OP_ADDIU, OP_LW, OP_LBU, OP_SW, OP_SB: alu_op = ALU_ADD;
            default:                          known  = 1'b0;
        endcase
    end

    always_comb begin
        o_id_ex           = '0;
        o_id_ex.valid     = i_instr_valid;
        o_id_ex.alu_op    = alu_op;
        o_id_ex.use_imm   = !is_rtype;
        o_id_ex.imm       = imm;
        o_id_ex.data_a    = i_rf_data_a;
        o_id_ex.data_b    = i_rf_data_b;
        o_id_ex.rs        = o_rs;
        o_id_ex.rt        = o_rt;
        o_id_ex.rd        = dest;
        o_id_ex.reg_write = i_instr_valid && known && !is_store && (dest != '0);
        o_id_ex.mem_read  = i_instr_valid && is_load;
        o_id_ex.mem_write = i_instr_valid && is_store;
        o_id_ex.byte_en   = (opcode == OP_LBU) || (opcode == OP_SB);
    end

    // Load in execute feeding this instruction
    assign o_stall = i_instr_valid && i_ex_mem_read && (i_ex_rd != '0) &&
                     ((uses_rs && o_rs == i_ex_rd) || (uses_rt && o_rt == i_ex_rd));

endmodule

`default_nettype wire

// File: verilog/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
    input  wire logic                        i_reset,
    input  wire logic [mips_pkg::NB_REG-1:0] i_EX_MEM_rd,
    input  wire logic [mips_pkg::NB_REG-1:0] i_MEM_WB_rd,
    input  wire logic [mips_pkg::NB_REG-1:0] i_rs,            // Operand A
    input  wire logic [mips_pkg::NB_REG-1:0] i_rt,            // Operand B
    input  wire logic                        i_EX_mem_write,  // Store in execute
    input  wire logic                        i_MEM_write_reg,
    input  wire logic                        i_WB_write_reg,
    output mips_pkg::fwd_sel_t               o_forwarding_a,
    output mips_pkg::fwd_sel_t               o_forwarding_b,
    output mips_pkg::store_sel_t             o_forwarding_mux_12
);

    import mips_pkg::*;

    logic hit_mem_a;
    logic hit_wb_a;
    logic hit_mem_b;
    logic hit_wb_b;

    assign hit_mem_a = i_MEM_write_reg && (i_EX_MEM_rd == i_rs);
    assign hit_wb_a  = i_WB_write_reg && (i_MEM_WB_rd == i_rs);
    assign hit_mem_b = i_MEM_write_reg && (i_EX_MEM_rd == i_rt);
    assign hit_wb_b  = i_WB_write_reg && (i_MEM_WB_rd == i_rt);

    always_comb begin
        o_forwarding_a      = FWD_NONE;
        o_forwarding_b      = FWD_NONE;
        o_forwarding_mux_12 = STORE_NORMAL;
        if (!i_reset) begin
            if (hit_mem_a) begin
                o_forwarding_a = FWD_MEM;   // Newer value wins
            end else if (hit_wb_a) begin
                o_forwarding_a = FWD_WB;
            end

            // A store takes rt through the store mux, not the ALU
            if (hit_mem_b) begin
                if (i_EX_mem_write) o_forwarding_mux_12 = STORE_MEM;
                else                o_forwarding_b      = FWD_MEM;
            end else if (hit_wb_b) begin
                if (i_EX_mem_write) o_forwarding_mux_12 = STORE_WB;
                else                o_forwarding_b      = FWD_WB;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire mips_pkg::alu_op_t            i_op,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_a,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_b,
    output logic [mips_pkg::NB_DATA-1:0]      o_result
);

    import mips_pkg::*;

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_SLT: o_result = {{(NB_DATA-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
            ALU_LUI: o_result = i_b << 16;  // Operand B carries the immediate
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  wire logic                         i_clk,
    input  wire logic                         i_mem_write,
    input  wire logic                         i_byte_en,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_addr,
    input  wire logic [mips_pkg::NB_DATA-1:0] i_wdata,
    input  wire logic                         i_mem_read,
    output logic [mips_pkg::NB_DATA-1:0]      o_rdata
);

    import mips_pkg::*;

    logic [NB_DATA-1:0]              mem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0]   word_idx;
    logic [1:0]                      lane;
    logic [NB_DATA-1:0]              word;

    assign word_idx = i_addr[$clog2(DMEM_WORDS)+1:2];
    assign lane     = i_addr[1:0];                   // Little-endian byte lane
    assign word     = mem[word_idx];

    always_ff @(posedge i_clk) begin
        if (i_mem_write) begin
            if (i_byte_en) begin
                mem[word_idx][8*lane +: 8] <= i_wdata[7:0];
            end else begin
                mem[word_idx] <= i_wdata;
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_mem_read) begin
            o_rdata = i_byte_en ? {24'h000000, word[8*lane +: 8]} : word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic [31:0]      o_wb_adr,
    input  wire logic [31:0] i_wb_dat,
    input  wire logic        i_wb_ack,
    output mips_pkg::retire_t o_retire
);

    import mips_pkg::*;

    logic [31:0]        instr;
    logic               instr_valid;
    logic               stall;
    logic [NB_REG-1:0]  rs;
    logic [NB_REG-1:0]  rt;
    logic [NB_DATA-1:0] rf_data_a;
    logic [NB_DATA-1:0] rf_data_b;
    id_ex_t             id_ex_d, id_ex_q;
    ex_mem_t            ex_mem_d, ex_mem_q;
    mem_wb_t            mem_wb_d, mem_wb_q;
    fwd_sel_t           fwd_a, fwd_b;
    store_sel_t         store_sel;
    logic [NB_DATA-1:0] alu_a, rt_val, alu_b, alu_result;
    logic [NB_DATA-1:0] store_data;
    logic [NB_DATA-1:0] dmem_rdata;

    instr_fetch u_instr_fetch (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(stall),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack),
        .o_instr(instr), .o_instr_valid(instr_valid)
    );

    register_file u_register_file (
        .i_clk(i_clk), .i_reset(i_reset), .i_rs(rs), .i_rt(rt),
        .o_data_a(rf_data_a), .o_data_b(rf_data_b),
        .i_we(mem_wb_q.reg_write), .i_waddr(mem_wb_q.rd), .i_wdata(mem_wb_q.wdata)
    );

    decode_unit u_decode_unit (
        .i_instr(instr), .i_instr_valid(instr_valid),
        .i_rf_data_a(rf_data_a), .i_rf_data_b(rf_data_b), .o_rs(rs), .o_rt(rt),
        .i_ex_rd(id_ex_q.rd), .i_ex_mem_read(id_ex_q.mem_read),
        .o_stall(stall), .o_id_ex(id_ex_d)
    );

    // Stall turns the decoded instruction into a bubble
    pipeline_reg #(.T(id_ex_t)) u_id_ex (
        .i_clk(i_clk), .i_reset(i_reset), .i_flush(stall), .i_d(id_ex_d), .o_q(id_ex_q)
    );

    forwarding_unit u_forwarding_unit (
        .i_reset(i_reset), .i_EX_MEM_rd(ex_mem_q.rd), .i_MEM_WB_rd(mem_wb_q.rd),
        .i_rs(id_ex_q.rs), .i_rt(id_ex_q.rt), .i_EX_mem_write(id_ex_q.mem_write),
        .i_MEM_write_reg(ex_mem_q.reg_write), .i_WB_write_reg(mem_wb_q.reg_write),
        .o_forwarding_a(fwd_a), .o_forwarding_b(fwd_b), .o_forwarding_mux_12(store_sel)
    );

    always_comb begin
        case (fwd_a)
            FWD_MEM: alu_a = ex_mem_q.alu_result;
            FWD_WB:  alu_a = mem_wb_q.wdata;
            default: alu_a = id_ex_q.data_a;
        endcase
        case (fwd_b)
            FWD_MEM: rt_val = ex_mem_q.alu_result;
            FWD_WB:  rt_val = mem_wb_q.wdata;
            default: rt_val = id_ex_q.data_b;
        endcase
        case (store_sel)
            STORE_MEM: store_data = ex_mem_q.alu_result;
            STORE_WB:  store_data = mem_wb_q.wdata;
            default:   store_data = id_ex_q.data_b;
        endcase
    end

    assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : rt_val;

    alu u_alu (.i_op(id_ex_q.alu_op), .i_a(alu_a), .i_b(alu_b), .o_result(alu_result));

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = store_data;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.reg_write  = id_ex_q.reg_write;
        ex_mem_d.mem_read   = id_ex_q.mem_read;
        ex_mem_d.mem_write  = id_ex_q.mem_write;
        ex_mem_d.byte_en    = id_ex_q.byte_en;
    end

    pipeline_reg #(.T(ex_mem_t)) u_ex_mem (
        .i_clk(i_clk), .i_reset(i_reset), .i_flush(1'b0), .i_d(ex_mem_d), .o_q(ex_mem_q)
    );

    data_memory u_data_memory (
        .i_clk(i_clk), .i_mem_write(ex_mem_q.mem_write), .i_byte_en(ex_mem_q.byte_en),
        .i_addr(ex_mem_q.alu_result), .i_wdata(ex_mem_q.store_data),
        .i_mem_read(ex_mem_q.mem_read), .o_rdata(dmem_rdata)
    );

    always_comb begin
        mem_wb_d.valid     = ex_mem_q.valid;
        mem_wb_d.wdata     = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_write = ex_mem_q.reg_write;
    end

    pipeline_reg #(.T(mem_wb_t)) u_mem_wb (
        .i_clk(i_clk), .i_reset(i_reset), .i_flush(1'b0), .i_d(mem_wb_d), .o_q(mem_wb_q)
    );

    // Report each register write once it has landed in the register file
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_retire <= '0;
        end else begin
            o_retire.valid <= mem_wb_q.valid && mem_wb_q.reg_write;
            o_retire.rd    <= mem_wb_q.rd;
            o_retire.wdata <= mem_wb_q.wdata;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    import mips_pkg::*;

    logic        i_clk;
    logic        i_reset;
    logic        o_wb_cyc;
    logic        o_wb_stb;
    logic [31:0] o_wb_adr;
    logic [31:0] i_wb_dat;
    logic        i_wb_ack;
    retire_t     o_retire;

    logic [31:0] imem [256];
    logic [31:0] model_mem [DMEM_WORDS];   // Persists across tests like the DUT memory
    logic [31:0] prog_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    logic [4:0]  got_rd_q [$];
    logic [31:0] got_val_q [$];
    integer      seed = 32'h47b4;
    int          error_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 200;         // Grows with each program
    int          waits;
    logic        busy;
    logic        random_waits = 1'b0;       // Zero wait states keep fetches back-to-back
    logic [31:0] exp_adr;

    mips_core u_mips_core (
        .i_clk(i_clk), .i_reset(i_reset), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb),
        .o_wb_adr(o_wb_adr), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack), .o_retire(o_retire)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, retires still missing", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Wishbone slave, 0 to 2 wait states per fetch
    always @(negedge i_clk) begin
        if (i_reset) begin
            i_wb_ack = 1'b0;
            busy     = 1'b0;
            exp_adr  = 32'h0;
        end else begin
            if (i_wb_ack) begin
                i_wb_ack = 1'b0;    // Taken on the last rising edge
                busy     = 1'b0;
            end
            if (o_wb_cyc && o_wb_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = random_waits ? $unsigned($random(seed)) % 3 : 0;
                    check_value("o_wb_adr", o_wb_adr, exp_adr);  // Sequential fetch
                    exp_adr = exp_adr + 32'd4;
                end
                if (waits == 0) begin
                    i_wb_ack = 1'b1;
                    i_wb_dat = imem[o_wb_adr[9:2]];
                end else begin
                    waits--;
                end
            end
        end
    end

    always @(negedge i_clk) begin
        if (!i_reset && o_retire.valid) begin
            got_rd_q.push_back(o_retire.rd);
            got_val_q.push_back(o_retire.wdata);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Instruction-level model, one instruction at a time in program order
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] word;
        logic [4:0]  dst;
        logic        wr;
        exp_rd_q.delete();
        exp_val_q.delete();
        for (int i = 0; i < 32; i++) regs[i] = 32'h0;
        foreach (prog_q[i]) begin
            ins  = prog_q[i];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            addr = a + {{16{ins[15]}}, ins[15:0]};
            word = model_mem[addr[7:2]];
            dst  = ins[20:16];
            wr   = 1'b1;
            res  = 32'h0;
            case (ins[31:26])
                OP_RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = addr;                     // Same sum as an address
                OP_ORI:   res = a | {16'h0000, ins[15:0]};
                OP_LUI:   res = {ins[15:0], 16'h0000};
                OP_LW:    res = word;
                OP_LBU:   res = (word >> (8 * addr[1:0])) & 32'hff;
                OP_SW: begin
                    wr = 1'b0;
                    model_mem[addr[7:2]] = b;
                end
                OP_SB: begin
                    wr = 1'b0;
                    word[8*addr[1:0] +: 8] = b[7:0];
                    model_mem[addr[7:2]] = word;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_rd_q.push_back(dst);
                exp_val_q.push_back(res);
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_reset = 1'b1;
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;
        check_value("o_wb_cyc", o_wb_cyc, 32'h0);
        check_value("o_wb_stb", o_wb_stb, 32'h0);
        check_value("o_retire.valid", o_retire.valid, 32'h0);
    endtask

    task automatic run_program();
        cycle_limit += prog_q.size() * 6;
        for (int i = 0; i < 256; i++) imem[i] = 32'h0;   // SLL r0 padding
        foreach (prog_q[i]) imem[i] = prog_q[i];
        run_model();
        apply_reset();
        got_rd_q.delete();
        got_val_q.delete();
        while (got_rd_q.size() < exp_rd_q.size()) @(negedge i_clk);
        repeat (12) @(negedge i_clk);                     // Catch stray retires
        if (got_rd_q.size() != exp_rd_q.size()) begin
            $display("Retire count wrong: expected %0d register writes, saw %0d",
                     exp_rd_q.size(), got_rd_q.size());
            error_count++;
        end
        foreach (exp_rd_q[i]) begin
            check_value("o_retire.rd", got_rd_q[i], exp_rd_q[i]);
            check_value("o_retire.wdata", got_val_q[i], exp_val_q[i]);
        end
        prog_q.delete();
    endtask

    task automatic alu_immediates();
        prog_q.push_back(itype_word(OP_ADDIU, 1, 0, 16'h0123));
        prog_q.push_back(itype_word(OP_ADDIU, 2, 0, 16'hfffb));  // -5
        prog_q.push_back(itype_word(OP_LUI, 3, 0, 16'h8000));
        prog_q.push_back(itype_word(OP_ORI, 4, 0, 16'hf0f0));
        repeat (3) prog_q.push_back(32'h0);
        prog_q.push_back(rtype_word(FN_ADDU, 5, 1, 4));
        prog_q.push_back(rtype_word(FN_SUBU, 6, 1, 2));
        prog_q.push_back(rtype_word(FN_AND, 7, 4, 2));
        prog_q.push_back(rtype_word(FN_OR, 8, 1, 3));
        prog_q.push_back(rtype_word(FN_SLT, 9, 2, 1));
        prog_q.push_back(rtype_word(FN_SLT, 10, 3, 2));
        prog_q.push_back(rtype_word(FN_SLT, 11, 1, 2));
        run_program();
    endtask

    task automatic dependent_chains();
        prog_q.push_back(itype_word(OP_ADDIU, 1, 0, 16'h0005));
        prog_q.push_back(rtype_word(FN_ADDU, 2, 1, 1));          // Distance 1
        prog_q.push_back(itype_word(OP_ADDIU, 3, 1, 16'h0001));  // Distance 2
        prog_q.push_back(rtype_word(FN_SUBU, 4, 1, 2));          // Distance 3 and 2
        prog_q.push_back(itype_word(OP_ADDIU, 5, 0, 16'h0001));
        prog_q.push_back(itype_word(OP_ADDIU, 5, 5, 16'h0002));
        prog_q.push_back(rtype_word(FN_ADDU, 6, 5, 5));          // Newer r5 wins
        prog_q.push_back(rtype_word(FN_OR, 7, 0, 6));
        run_program();
    endtask

    task automatic store_forwarding();
        prog_q.push_back(itype_word(OP_ADDIU, 1, 0, 16'h0040));
        prog_q.push_back(itype_word(OP_LUI, 2, 0, 16'h1234));
        prog_q.push_back(itype_word(OP_ORI, 2, 2, 16'h5678));
        prog_q.push_back(itype_word(OP_SW, 2, 1, 16'h0000));
        prog_q.push_back(itype_word(OP_ADDIU, 4, 0, 16'hfffe));
        prog_q.push_back(itype_word(OP_ADDIU, 5, 0, 16'h0033));
        prog_q.push_back(itype_word(OP_SW, 4, 1, 16'h0004));
        prog_q.push_back(itype_word(OP_ADDIU, 3, 0, 16'h009c));
        prog_q.push_back(itype_word(OP_SB, 3, 1, 16'h0005));
        prog_q.push_back(itype_word(OP_ADDIU, 6, 0, 16'h01a5));
        prog_q.push_back(32'h0);
        prog_q.push_back(itype_word(OP_SB, 6, 1, 16'h0003));
        prog_q.push_back(itype_word(OP_LW, 7, 1, 16'h0000));
        prog_q.push_back(itype_word(OP_LW, 8, 1, 16'h0004));
        prog_q.push_back(itype_word(OP_LBU, 9, 1, 16'h0005));
        prog_q.push_back(itype_word(OP_LBU, 10, 1, 16'h0003));
        run_program();
    endtask

    task automatic load_use();
        prog_q.push_back(itype_word(OP_ADDIU, 1, 0, 16'h0080));
        prog_q.push_back(itype_word(OP_ADDIU, 2, 0, 16'h0077));
        prog_q.push_back(itype_word(OP_SW, 2, 1, 16'h0000));
        prog_q.push_back(itype_word(OP_LW, 3, 1, 16'h0000));
        prog_q.push_back(rtype_word(FN_ADDU, 4, 3, 3));
        prog_q.push_back(itype_word(OP_LBU, 5, 1, 16'h0000));
        prog_q.push_back(itype_word(OP_ADDIU, 6, 5, 16'h0001));
        prog_q.push_back(itype_word(OP_LW, 7, 1, 16'h0000));
        prog_q.push_back(itype_word(OP_SW, 7, 1, 16'h0004));     // Stalls on store data
        prog_q.push_back(itype_word(OP_LW, 8, 1, 16'h0004));
        prog_q.push_back(rtype_word(FN_OR, 9, 0, 8));
        prog_q.push_back(itype_word(OP_ADDIU, 10, 0, 16'h0003));
        run_program();
    endtask

    task automatic zero_register();
        prog_q.push_back(itype_word(OP_ADDIU, 0, 0, 16'h0055));
        prog_q.push_back(rtype_word(FN_ADDU, 1, 0, 0));
        prog_q.push_back(itype_word(OP_ORI, 0, 0, 16'hffff));
        prog_q.push_back(32'h0);
        prog_q.push_back(rtype_word(FN_OR, 2, 0, 0));
        prog_q.push_back(itype_word(OP_ADDIU, 3, 0, 16'h0040));
        prog_q.push_back(itype_word(OP_LW, 0, 3, 16'h0000));
        prog_q.push_back(rtype_word(FN_ADDU, 4, 0, 3));
        run_program();
    endtask

    task automatic wait_state_fetch();
        random_waits = 1'b1;
        for (int k = 1; k < 16; k++) begin
            prog_q.push_back(itype_word(OP_ADDIU, 5'(k), 5'(k - 1), 16'(k * 3)));
        end
        prog_q.push_back(rtype_word(FN_ADDU, 16, 15, 1));
        prog_q.push_back(itype_word(OP_SW, 16, 0, 16'h0008));
        prog_q.push_back(itype_word(OP_LW, 17, 0, 16'h0008));
        prog_q.push_back(rtype_word(FN_SUBU, 18, 17, 15));
        run_program();
    endtask

    initial begin
        i_reset  = 1'b1;
        i_wb_ack = 1'b0;
        i_wb_dat = 32'h0;
        alu_immediates();
        dependent_chains();
        store_forwarding();
        load_use();
        zero_register();
        wait_state_fetch();
        $display("Run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/mips_pkg.sv
verilog/pipeline_reg.sv
verilog/instr_fetch.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/mips_core.sv
tb/tb_mips_core.sv
